// ==== rtl/limn_consts.svh ====
`ifndef LIMN_CONSTS_SVH
`define LIMN_CONSTS_SVH

// Datapath width
`define LIMN_XLEN 32

// General purpose registers, r0 reads as zero
`define LIMN_NREGS 32

// JAL link target
`define LIMN_REG_LR 31

// First issue pc after reset
`define LIMN_RESET_PC 32'hFFFE0000

// Primary opcode field, bits 5:0 of every format
`define LIMN_OP_W 6

`endif

// ==== rtl/limn_isa_pkg.sv ====
`include "limn_consts.svh"

package limn_isa_pkg;

    typedef logic [$clog2(`LIMN_NREGS)-1:0] limn_reg_t;

    // Register form, group 111001
    typedef struct packed {
        logic [5:0]            funct;   // ALU op in 4:2, shift mode in 1:0
        limn_reg_t             rd4;     // Shift amount
        limn_reg_t             rs3;
        limn_reg_t             rs2;
        limn_reg_t             rd1;
        logic [`LIMN_OP_W-1:0] opcode;
    } limn_reg_fmt_t;

    typedef struct packed {
        logic [15:0]           imm16;
        limn_reg_t             rs2;
        limn_reg_t             rd1;
        logic [`LIMN_OP_W-1:0] opcode;
    } limn_imm_fmt_t;

    typedef struct packed {
        logic [20:0]           imm21;   // Bit 20 set for backward
        limn_reg_t             rd1;     // Register under test
        logic [`LIMN_OP_W-1:0] opcode;
    } limn_br_fmt_t;

    // JAL and J, only opcode bits 2:1 are fixed
    typedef struct packed {
        logic [28:0] imm29;
        logic [1:0]  op_mid;
        logic        link;
    } limn_jump_fmt_t;

    typedef union packed {
        limn_reg_fmt_t  r;
        limn_imm_fmt_t  i;
        limn_br_fmt_t   b;
        limn_jump_fmt_t j;
    } limn_inst_t;

    typedef enum logic [2:0] {
        ALU_NONE = 3'd0, ALU_OR  = 3'd1, ALU_XOR = 3'd2, ALU_AND = 3'd3,
        ALU_SLTS = 3'd4, ALU_SLT = 3'd5, ALU_SUB = 3'd6, ALU_ADD = 3'd7
    } limn_alu_op_t;

    typedef enum logic [1:0] {
        SHIFT_RIGHT = 2'd0, SHIFT_LEFT = 2'd1, SHIFT_ARITH = 2'd2, SHIFT_ARITH_ALT = 2'd3
    } limn_shift_t;

    typedef enum logic [2:0] {
        KIND_ALU_REG, KIND_ALU_IMM, KIND_LUI, KIND_NOR,
        KIND_BRANCH, KIND_JAL, KIND_JALR, KIND_ILLEGAL
    } limn_kind_t;

    typedef enum logic [1:0] {
        BR_EQ, BR_NE, BR_LT, BR_NONE
    } limn_br_cond_t;

endpackage

// ==== rtl/limn_core_pkg.sv ====
`include "limn_consts.svh"

package limn_core_pkg;

    typedef logic [`LIMN_XLEN-1:0] limn_word_t;

    // Execute stage register
    typedef struct packed {
        logic                             valid;
        limn_isa_pkg::limn_kind_t         kind;
        limn_isa_pkg::limn_alu_op_t       alu_op;
        limn_isa_pkg::limn_br_cond_t      br_cond;
        limn_isa_pkg::limn_shift_t        shift;
        logic [$clog2(`LIMN_XLEN)-1:0]    shamt;
        limn_isa_pkg::limn_reg_t          rd;
        limn_word_t                       a;     // rs2, or rd1 for branches
        limn_word_t                       b;     // rs3 or zero-extended imm16
        limn_word_t                       imm;   // Raw offset field for pc math
        limn_word_t                       pc;
        limn_isa_pkg::limn_inst_t         inst;
    } limn_issue_t;

    typedef struct packed {
        logic                    wen;
        limn_isa_pkg::limn_reg_t rd;
        limn_word_t              value;
    } limn_alu_res_t;

    typedef struct packed {
        logic       taken;
        limn_word_t next_pc;
    } limn_br_res_t;

    typedef struct packed {
        limn_word_t              pc;
        limn_word_t              next_pc;
        logic                    wb_en;
        limn_isa_pkg::limn_reg_t wb_reg;
        limn_word_t              wb_data;
        logic                    illegal;
    } limn_retire_t;

endpackage

// ==== rtl/limn_regfile.sv ====
`timescale 1ns/1ps
`include "limn_consts.svh"

module limn_regfile
    import limn_isa_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  limn_reg_t             rd_addr_a,
    input  limn_reg_t             rd_addr_b,
    input  logic                  wr_en,
    input  limn_reg_t             wr_addr,
    input  logic [`LIMN_XLEN-1:0] wr_data,
    output logic [`LIMN_XLEN-1:0] rd_data_a,
    output logic [`LIMN_XLEN-1:0] rd_data_b
);

    logic [`LIMN_XLEN-1:0] regs [`LIMN_NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `LIMN_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin  // r0 never written
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

// ==== rtl/limn_decode.sv ====
`timescale 1ns/1ps
`include "limn_consts.svh"

module limn_decode
    import limn_isa_pkg::*;
    import limn_core_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          inst_valid,
    input  limn_inst_t    inst,
    input  limn_word_t    rd_data_a,
    input  limn_word_t    rd_data_b,
    input  limn_alu_res_t bypass,
    input  limn_word_t    redirect_pc,
    output limn_reg_t     rd_addr_a,
    output limn_reg_t     rd_addr_b,
    output limn_issue_t   issue
);

    limn_kind_t    kind;
    limn_alu_op_t  alu_op;
    limn_br_cond_t br_cond;
    limn_word_t    imm_zx;
    limn_word_t    cur_pc;
    limn_word_t    pc_q;
    limn_issue_t   issue_d;

    // Result still in execute wins over the register file
    function automatic limn_word_t fwd(
        input limn_reg_t     addr,
        input limn_word_t    rf_data,
        input limn_alu_res_t byp
    );
        if (byp.wen && byp.rd == addr && addr != '0) begin
            return byp.value;
        end
        return rf_data;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Opcode classification

    always_comb begin
        kind    = KIND_ILLEGAL;
        alu_op  = ALU_NONE;
        br_cond = BR_NONE;
        casez (inst.r.opcode)
            6'b11_1000: kind = KIND_JALR;
            6'b??_?11?: kind = KIND_JAL;   // J when link bit is clear
            6'b11_1101: begin
                kind    = KIND_BRANCH;
                br_cond = BR_EQ;
            end
            6'b11_0101: begin
                kind    = KIND_BRANCH;
                br_cond = BR_NE;
            end
            6'b10_1101: begin
                kind    = KIND_BRANCH;
                br_cond = BR_LT;
            end
            6'b??_?100: begin
                kind   = (inst.i.opcode[5:3] == 3'b000) ? KIND_LUI : KIND_ALU_IMM;
                alu_op = limn_alu_op_t'(inst.i.opcode[5:3]);
            end
            6'b11_1001: begin
                casez (inst.r.funct[5:2])
                    4'b0000: kind = KIND_NOR;
                    4'b1???: kind = KIND_ILLEGAL;  // Indexed moves
                    default: begin
                        kind   = KIND_ALU_REG;
                        alu_op = limn_alu_op_t'(inst.r.funct[4:2]);
                    end
                endcase
            end
            default: kind = KIND_ILLEGAL;
        endcase
    end

    // Branches test rd1, everything else reads rs2
    assign rd_addr_a = (kind == KIND_BRANCH) ? inst.b.rd1 : inst.r.rs2;
    assign rd_addr_b = inst.r.rs3;

    assign imm_zx = {16'b0, inst.i.imm16};
    assign cur_pc = issue.valid ? redirect_pc : pc_q;

    //////////////////////////////////////////////////////////////////////
    // Issue record

    always_comb begin
        issue_d.valid   = inst_valid;
        issue_d.kind    = kind;
        issue_d.alu_op  = alu_op;
        issue_d.br_cond = br_cond;
        issue_d.shift   = limn_shift_t'(inst.r.funct[1:0]);
        issue_d.shamt   = inst.r.rd4;
        issue_d.rd      = (kind == KIND_JAL) ? limn_reg_t'(`LIMN_REG_LR) : inst.r.rd1;
        issue_d.a       = fwd(rd_addr_a, rd_data_a, bypass);
        issue_d.b       = (kind == KIND_ALU_IMM || kind == KIND_LUI)
                        ? imm_zx : fwd(rd_addr_b, rd_data_b, bypass);
        case (kind)
            KIND_BRANCH: issue_d.imm = {11'b0, inst.b.imm21};
            KIND_JAL:    issue_d.imm = {3'b0, inst.j.imm29};
            default:     issue_d.imm = imm_zx;
        endcase
        issue_d.pc      = cur_pc;
        issue_d.inst    = inst;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issue.valid <= 1'b0;
            pc_q        <= `LIMN_RESET_PC;
        end else begin
            issue <= issue_d;
            pc_q  <= cur_pc;   // Holds next pc across idle cycles
        end
    end

endmodule

// ==== rtl/limn_alu_unit.sv ====
`timescale 1ns/1ps
`include "limn_consts.svh"

module limn_alu_unit
    import limn_isa_pkg::*;
    import limn_core_pkg::*;
(
    input  limn_issue_t   issue,
    output limn_alu_res_t alu_res
);

    limn_word_t shifted;
    limn_word_t pc_plus4;
    limn_word_t value;
    logic       writes;

    function automatic limn_word_t alu_calc(
        input limn_alu_op_t op,
        input limn_word_t   a,
        input limn_word_t   b
    );
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_XOR:  return a ^ b;
            ALU_OR:   return a | b;
            ALU_SLT:  return limn_word_t'(a < b);
            ALU_SLTS: return limn_word_t'($signed(a) < $signed(b));
            default:  return '0;
        endcase
    endfunction

    // Third operand shifter, register forms only
    always_comb begin
        shifted = issue.b;
        if (issue.kind == KIND_ALU_REG || issue.kind == KIND_NOR) begin
            case (issue.shift)
                SHIFT_RIGHT: shifted = issue.b >> issue.shamt;
                SHIFT_LEFT:  shifted = issue.b << issue.shamt;
                SHIFT_ARITH, SHIFT_ARITH_ALT: begin
                    shifted = limn_word_t'($signed(issue.b) >>> issue.shamt);
                end
            endcase
        end
    end

    assign pc_plus4 = issue.pc + 32'd4;

    always_comb begin
        value  = '0;
        writes = 1'b0;
        case (issue.kind)
            KIND_ALU_REG, KIND_ALU_IMM: begin
                value  = alu_calc(issue.alu_op, issue.a, shifted);
                writes = 1'b1;
            end
            KIND_NOR: begin
                value  = ~(issue.a | shifted);
                writes = 1'b1;
            end
            KIND_LUI: begin
                value  = issue.a | (issue.b << 16);
                writes = 1'b1;
            end
            KIND_JAL: begin
                value  = pc_plus4;
                writes = issue.inst.j.link;   // Plain J leaves lr alone
            end
            KIND_JALR: begin
                value  = pc_plus4;
                writes = 1'b1;
            end
            default: ;
        endcase
    end

    assign alu_res.wen   = issue.valid && writes && (issue.rd != '0);
    assign alu_res.rd    = issue.rd;
    assign alu_res.value = value;

endmodule

// ==== rtl/limn_branch_unit.sv ====
`timescale 1ns/1ps
`include "limn_consts.svh"

module limn_branch_unit
    import limn_isa_pkg::*;
    import limn_core_pkg::*;
(
    input  limn_issue_t  issue,
    output limn_br_res_t br_res
);

    limn_word_t pc_plus4;
    limn_word_t br_target;
    logic       cond_met;
    logic       jump;

    assign pc_plus4 = issue.pc + 32'd4;

    always_comb begin
        case (issue.br_cond)
            BR_EQ:   cond_met = (issue.a == '0);
            BR_NE:   cond_met = (issue.a != '0);
            BR_LT:   cond_met = issue.a[`LIMN_XLEN-1];   // Sign bit only
            default: cond_met = 1'b0;
        endcase
    end

    // Offset is a magnitude in words, imm21[20] picks the direction
    assign br_target = issue.imm[20]
                     ? issue.pc - {10'b0, ~issue.imm[19:0], 2'b00}
                     : issue.pc + {10'b0, issue.imm[19:0], 2'b00};

    always_comb begin
        jump           = 1'b0;
        br_res.next_pc = pc_plus4;
        case (issue.kind)
            KIND_BRANCH: begin
                if (cond_met) begin
                    jump           = 1'b1;
                    br_res.next_pc = br_target;
                end
            end
            KIND_JAL: begin
                jump           = 1'b1;
                br_res.next_pc = {issue.pc[31], issue.imm[28:0], 2'b00};  // Stays in half
            end
            KIND_JALR: begin
                jump           = 1'b1;
                br_res.next_pc = issue.a + {14'b0, issue.imm[15:0], 2'b00};
            end
            default: ;
        endcase
    end

    assign br_res.taken = issue.valid && jump;

endmodule

// ==== rtl/limn_commit.sv ====
`timescale 1ns/1ps
`include "limn_consts.svh"

module limn_commit
    import limn_isa_pkg::*;
    import limn_core_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  limn_issue_t   issue,
    input  limn_alu_res_t alu_res,
    input  limn_br_res_t  br_res,
    output logic          wr_en,
    output limn_reg_t     wr_addr,
    output limn_word_t    wr_data,
    output logic          retire_valid,
    output limn_retire_t  retire
);

    limn_retire_t retire_d;

    // Register file captures these on the retire edge
    assign wr_en   = alu_res.wen;   // Already qualified by issue.valid
    assign wr_addr = alu_res.rd;
    assign wr_data = alu_res.value;

    always_comb begin
        retire_d.pc      = issue.pc;
        retire_d.next_pc = br_res.next_pc;
        retire_d.wb_en   = alu_res.wen;
        retire_d.wb_reg  = alu_res.rd;
        retire_d.wb_data = alu_res.value;
        retire_d.illegal = (issue.kind == KIND_ILLEGAL);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        retire <= retire_d;
    end

endmodule

// ==== rtl/limn_core.sv ====
`timescale 1ns/1ps
`include "limn_consts.svh"

module limn_core
    import limn_isa_pkg::*;
    import limn_core_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         inst_valid,
    input  limn_inst_t   inst,
    output logic         retire_valid,
    output limn_retire_t retire
);

    limn_reg_t     rd_addr_a;
    limn_reg_t     rd_addr_b;
    limn_word_t    rd_data_a;
    limn_word_t    rd_data_b;
    limn_issue_t   issue;      // Execute stage
    limn_alu_res_t alu_res;
    limn_br_res_t  br_res;
    logic          wr_en;
    limn_reg_t     wr_addr;
    limn_word_t    wr_data;

    //////////////////////////////////////////////////////////////////////
    // Issue

    limn_regfile regfile_i (
        .clk       (clk),
        .rst       (rst),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    limn_decode decode_i (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .bypass      (alu_res),          // Forwarding from execute
        .redirect_pc (br_res.next_pc),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .issue       (issue)
    );

    //////////////////////////////////////////////////////////////////////
    // Execute and retire

    limn_alu_unit alu_unit_i (
        .issue   (issue),
        .alu_res (alu_res)
    );

    limn_branch_unit branch_unit_i (
        .issue  (issue),
        .br_res (br_res)
    );

    limn_commit commit_i (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .alu_res      (alu_res),
        .br_res       (br_res),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

// ==== bench/limn_core_sva.sv ====
`timescale 1ns/1ps
`include "limn_consts.svh"

module limn_core_sva
    import limn_core_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input logic         inst_valid,
    input logic         retire_valid,
    input limn_retire_t retire
);

    // Fixed two stage pipe, no stalls
    a_retire_latency: assert property (
        @(posedge clk) disable iff (rst)
        inst_valid |-> ##2 retire_valid
    ) else $error("retire_valid missing 2 cycles after inst_valid");

    a_retire_source: assert property (
        @(posedge clk) disable iff (rst)
        retire_valid |-> $past(inst_valid, 2)
    ) else $error("retire_valid without inst_valid 2 cycles earlier");

    a_reset_clears: assert property (
        @(posedge clk) rst |=> !retire_valid
    ) else $error("retire_valid high right after reset");

    a_no_r0_write: assert property (
        @(posedge clk) disable iff (rst)
        (retire_valid && retire.wb_en) |-> (retire.wb_reg != '0)
    ) else $error("retire writes r0");

endmodule

bind limn_core limn_core_sva sva_i (
    .clk          (clk),
    .rst          (rst),
    .inst_valid   (inst_valid),
    .retire_valid (retire_valid),
    .retire       (retire)
);

// ==== bench/limn_core_tb.sv ====
`timescale 1ns/1ps
`include "limn_consts.svh"

module limn_core_tb
    import limn_isa_pkg::*;
    import limn_core_pkg::*;
();

    localparam int          CLK_PERIOD = 4;
    localparam int          MAX_TESTS  = 40;
    localparam logic [31:0] PC0        = `LIMN_RESET_PC;

    // Primary opcodes
    localparam logic [5:0] OP_ADDI = 6'h3C;
    localparam logic [5:0] OP_SUBI = 6'h34;
    localparam logic [5:0] OP_SLTI = 6'h2C;
    localparam logic [5:0] OP_ANDI = 6'h1C;
    localparam logic [5:0] OP_XORI = 6'h14;
    localparam logic [5:0] OP_ORI  = 6'h0C;
    localparam logic [5:0] OP_LUI  = 6'h04;
    localparam logic [5:0] OP_BEQ  = 6'h3D;
    localparam logic [5:0] OP_BNE  = 6'h35;
    localparam logic [5:0] OP_BLT  = 6'h2D;
    localparam logic [5:0] OP_JALR = 6'h38;
    localparam logic [5:0] OP_REG  = 6'h39;

    typedef struct packed {
        logic [31:0] inst;
        logic        wb_en;
        logic [4:0]  wb_reg;
        logic [31:0] wb_data;
        logic [31:0] next_pc;
        logic        illegal;
    } test_vec_t;

    logic         clk;
    logic         rst;
    logic         inst_valid;
    limn_inst_t   inst;
    logic         retire_valid;
    limn_retire_t retire;

    test_vec_t    vecs [MAX_TESTS];
    string        names [MAX_TESTS];
    int           n_tests      = 0;
    logic         table_ready  = 1'b0;
    int           seed;
    int           cur_idx;      // Table entry currently on inst
    int           pending [$];  // Issued but not yet retired
    int           issued_at [$];  // Issue cycle of each pending entry
    int           cycle        = 0;
    logic [31:0]  exp_pc       = PC0;
    int           retired      = 0;
    int           passed       = 0;
    int           failed_tests = 0;
    int           errors       = 0;

    limn_core dut_i (
        .clk          (clk),
        .rst          (rst),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Instruction encoders

    function automatic logic [31:0] reg_word(
        input logic [2:0] op3,
        input logic [1:0] shift,
        input logic [4:0] shamt,
        input logic [4:0] rs3,
        input logic [4:0] rs2,
        input logic [4:0] rd
    );
        return {1'b0, op3, shift, shamt, rs3, rs2, rd, OP_REG};
    endfunction

    function automatic logic [31:0] imm_word(
        input logic [5:0]  op,
        input logic [15:0] imm,
        input logic [4:0]  rs2,
        input logic [4:0]  rd
    );
        return {imm, rs2, rd, op};
    endfunction

    function automatic logic [31:0] br_word(
        input logic [5:0]  op,
        input logic [20:0] imm21,
        input logic [4:0]  rd
    );
        return {imm21, rd, op};
    endfunction

    function automatic logic [31:0] jump_word(input logic [28:0] imm29, input logic link);
        return {imm29, 2'b11, link};
    endfunction

    task automatic add_test(
        input string       name,
        input logic [31:0] word,
        input logic        wb_en,
        input logic [4:0]  wb_reg,
        input logic [31:0] wb_data,
        input logic [31:0] next_pc,
        input logic        illegal
    );
        names[n_tests] = name;
        vecs[n_tests]  = '{word, wb_en, wb_reg, wb_data, next_pc, illegal};
        n_tests++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus table
    // Setup leaves r1 at 0x1234, r2 at 0x80000005 and r3 at 0xABCD1234

    task automatic build_table();
        add_test("addi_r1", imm_word(OP_ADDI, 'h1234, 0, 1), 1, 1, 'h0000_1234, PC0 + 'h04, 0);
        add_test("lui_r2", imm_word(OP_LUI, 'h8000, 0, 2), 1, 2, 'h8000_0000, PC0 + 'h08, 0);
        add_test("ori_r2", imm_word(OP_ORI, 'h0005, 2, 2), 1, 2, 'h8000_0005, PC0 + 'h0C, 0);
        add_test("lui_r3", imm_word(OP_LUI, 'hABCD, 1, 3), 1, 3, 'hABCD_1234, PC0 + 'h10, 0);
        add_test("subi_r4", imm_word(OP_SUBI, 'h0034, 1, 4), 1, 4, 'h0000_1200, PC0 + 'h14, 0);
        add_test("add_r5", reg_word(ALU_ADD, SHIFT_RIGHT, 0, 4, 1, 5), 1, 5, 'h2434,
                 PC0 + 'h18, 0);
        add_test("sub_r6", reg_word(ALU_SUB, SHIFT_RIGHT, 0, 1, 5, 6), 1, 6, 'h1200,
                 PC0 + 'h1C, 0);
        add_test("and_r7", reg_word(ALU_AND, SHIFT_RIGHT, 0, 5, 3, 7), 1, 7, 'h0034,
                 PC0 + 'h20, 0);
        add_test("xor_r8", reg_word(ALU_XOR, SHIFT_RIGHT, 0, 3, 7, 8), 1, 8, 'hABCD_1200,
                 PC0 + 'h24, 0);
        add_test("or_r9", reg_word(ALU_OR, SHIFT_RIGHT, 0, 2, 8, 9), 1, 9, 'hABCD_1205,
                 PC0 + 'h28, 0);
        add_test("nor_r10", reg_word(ALU_NONE, SHIFT_RIGHT, 0, 0, 9, 10), 1, 10, 'h5432_EDFA,
                 PC0 + 'h2C, 0);
        // Mixed signs make unsigned and signed compares disagree
        add_test("slt_r11", reg_word(ALU_SLT, SHIFT_RIGHT, 0, 2, 1, 11), 1, 11, 1,
                 PC0 + 'h30, 0);
        add_test("slts_r12", reg_word(ALU_SLTS, SHIFT_RIGHT, 0, 2, 1, 12), 1, 12, 0,
                 PC0 + 'h34, 0);
        add_test("slts_r13", reg_word(ALU_SLTS, SHIFT_RIGHT, 0, 1, 2, 13), 1, 13, 1,
                 PC0 + 'h38, 0);
        add_test("srl_r14", reg_word(ALU_ADD, SHIFT_RIGHT, 4, 2, 0, 14), 1, 14, 'h0800_0000,
                 PC0 + 'h3C, 0);
        add_test("sll_r15", reg_word(ALU_ADD, SHIFT_LEFT, 8, 1, 0, 15), 1, 15, 'h0012_3400,
                 PC0 + 'h40, 0);
        add_test("sra_r16", reg_word(ALU_OR, SHIFT_ARITH, 4, 2, 0, 16), 1, 16, 'hF800_0000,
                 PC0 + 'h44, 0);
        add_test("slti_r17", imm_word(OP_SLTI, 'h0001, 2, 17), 1, 17, 0, PC0 + 'h48, 0);
        // Backward offsets hold the inverted word count
        add_test("beq_fwd_taken", br_word(OP_BEQ, 'h00010, 0), 0, 0, 0, PC0 + 'h88, 0);
        add_test("bne_fwd_not_taken", br_word(OP_BNE, 'h00010, 0), 0, 0, 0, PC0 + 'h8C, 0);
        add_test("blt_back_taken", br_word(OP_BLT, 'h1F_FFF7, 2), 0, 0, 0, PC0 + 'h6C, 0);
        add_test("beq_fwd_not_taken", br_word(OP_BEQ, 'h00010, 1), 0, 0, 0, PC0 + 'h70, 0);
        add_test("bne_back_taken", br_word(OP_BNE, 'h1F_FFFB, 1), 0, 0, 0, PC0 + 'h60, 0);
        add_test("blt_not_taken", br_word(OP_BLT, 'h00010, 1), 0, 0, 0, PC0 + 'h64, 0);
        add_test("addi_after_branch", imm_word(OP_ADDI, 'h0042, 0, 18), 1, 18, 'h42,
                 PC0 + 'h68, 0);
        add_test("jal_link", jump_word('h400, 1), 1, 31, PC0 + 'h6C, 'h8000_1000, 0);
        add_test("j_no_link", jump_word('h800, 0), 0, 0, 0, 'h8000_2000, 0);
        add_test("jalr_r19", imm_word(OP_JALR, 'h0010, 1, 19), 1, 19, 'h8000_2004,
                 'h0000_1274, 0);
        add_test("illegal_opcode", imm_word(6'h00, 'h1111, 1, 20), 0, 0, 0, 'h0000_1278, 1);
        add_test("illegal_funct", 'h8000_0539, 0, 0, 0, 'h0000_127C, 1);  // Indexed move
        add_test("addi_to_r0", imm_word(OP_ADDI, 'h0005, 1, 0), 0, 0, 0, 'h0000_1280, 0);
        add_test("read_r0", reg_word(ALU_OR, SHIFT_RIGHT, 0, 0, 0, 21), 1, 21, 0,
                 'h0000_1284, 0);
        add_test("read_link", reg_word(ALU_ADD, SHIFT_RIGHT, 0, 0, 31, 22), 1, 22, PC0 + 'h6C,
                 'h0000_1288, 0);
        add_test("andi_r23", imm_word(OP_ANDI, 'hFF00, 3, 23), 1, 23, 'h0000_1200,
                 'h0000_128C, 0);
        add_test("xori_r24", imm_word(OP_XORI, 'hFFFF, 2, 24), 1, 24, 'h8000_FFFA,
                 'h0000_1290, 0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checking

    task automatic check_value(
        input string       test,
        input string       field,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (actual !== expected) begin
            $display("mismatch %s %s: expected %h, actual %h", test, field, expected, actual);
            errors++;
        end
    endtask

    task automatic check_retire();
        int        idx;
        int        issue_cyc;
        int        errs_before;
        test_vec_t t;
        if (pending.size() == 0) begin
            $display("retire_valid seen with no instruction outstanding at %0t", $time);
            errors++;
            return;
        end
        idx         = pending.pop_front();
        issue_cyc   = issued_at.pop_front();
        t           = vecs[idx];
        errs_before = errors;
        check_value(names[idx], "latency", 2, cycle - issue_cyc);
        check_value(names[idx], "pc", exp_pc, retire.pc);
        check_value(names[idx], "next_pc", t.next_pc, retire.next_pc);
        check_value(names[idx], "wb_en", t.wb_en, retire.wb_en);
        check_value(names[idx], "illegal", t.illegal, retire.illegal);
        if (t.wb_en) begin
            check_value(names[idx], "wb_reg", t.wb_reg, retire.wb_reg);
            check_value(names[idx], "wb_data", t.wb_data, retire.wb_data);
        end
        exp_pc = t.next_pc;   // Next retire must carry this pc
        retired++;
        if (errors == errs_before) begin
            passed++;
            $display("test %s: ok", names[idx]);
        end else begin
            failed_tests++;
            $display("test %s: wrong", names[idx]);
        end
    endtask

    // Sample away from the driving edge
    always @(negedge clk) begin
        if (!rst) begin
            cycle++;
            if (inst_valid) begin
                pending.push_back(cur_idx);
                issued_at.push_back(cycle);
            end
            if (retire_valid) begin
                check_retire();
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus and end of run

    initial begin
        int gap;
        seed       = 55;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        cur_idx    = 0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < n_tests; i++) begin
            @(posedge clk);
            inst_valid <= 1'b1;
            inst       <= vecs[i].inst;
            cur_idx    <= i;
            gap = $random(seed) & 7;
            if (gap == 0) begin   // Occasional idle cycle
                @(posedge clk);
                inst_valid <= 1'b0;
            end
        end
        @(posedge clk);
        inst_valid <= 1'b0;
        wait (retired == n_tests);
        repeat (4) @(posedge clk);   // Catch stray retires
        $display("summary: %0d tests, %0d ok, %0d wrong, %0d check errors",
                 n_tests, passed, failed_tests, errors);
        if (errors == 0 && failed_tests == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Three cycles per entry covers gaps and pipeline latency
    initial begin
        wait (table_ready);
        repeat (n_tests * 3 + 20) @(posedge clk);
        $display("watchdog expired with %0d of %0d tests retired", retired, n_tests);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+rtl
rtl/limn_isa_pkg.sv
rtl/limn_core_pkg.sv
rtl/limn_regfile.sv
rtl/limn_decode.sv
rtl/limn_alu_unit.sv
rtl/limn_branch_unit.sv
rtl/limn_commit.sv
rtl/limn_core.sv
bench/limn_core_sva.sv
bench/limn_core_tb.sv
